//--- hw/histDataPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel data types. Sixteen 8-bit pixels per word, lane 0 in the low byte
// Scratch tags are fixed; any other tag reads as an empty bin
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package histDataPkg;

  localparam int pixelBits = 8;
  localparam int wordBits = 128;

  // Pixels per image word
  localparam int lanesPerWord = wordBits / pixelBits;

  typedef logic [pixelBits-1:0] pixelT;
  typedef logic [wordBits-1:0] imageWordT;

  // One scratchpad word, either a count or an output level
  typedef union packed {
    struct packed {
      logic [15:0] tag;
      logic [15:0] count;
    } countView;
    struct packed {
      logic [15:0] tag;
      logic [7:0] level;
      logic [7:0] unused;
    } mapView;
  } scratchEntryT;

  // Entry holds a count from this run
  localparam logic [15:0] countTag = 16'hAAAA;
  // Entry holds an output level
  localparam logic [15:0] mapTag = 16'h5555;

endpackage

//--- hw/histCtrlPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run phases and scratchpad geometry; one bin per 8-bit pixel value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package histCtrlPkg;

  // Run order is idle, histogram, mapping, remap, idle
  typedef enum logic [1:0] {
    phaseIdle,
    phaseHistogram,
    phaseMapping,
    phaseRemap
  } runPhaseT;

  // Scratchpad depth
  localparam int binCount = 256;

  typedef logic [7:0] binAddrT;

endpackage

//--- hw/memPort.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One read and one write port of a memory; readData is one clock late
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface memPort #(
  parameter int addrWidth = 16,
  parameter int dataWidth = 128
);
  logic [addrWidth-1:0] readAddr;
  logic [dataWidth-1:0] readData;
  logic [addrWidth-1:0] writeAddr;
  logic [dataWidth-1:0] writeData;
  logic writeEnable;

  // Block side
  modport master (output readAddr, writeAddr, writeData, writeEnable, input readData);
  // Memory side
  modport slave (input readAddr, writeAddr, writeData, writeEnable, output readData);
endinterface

//--- hw/wordMemory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register memory, contents survive reset. Address high bits are ignored
// Read during a write to the same word returns the old data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module wordMemory #(
  parameter int dataWidth = 128,
  parameter int depth = 4
) (
  input logic clock,
  memPort.slave port
);

  // Index width, at least one bit
  localparam int indexBits = (depth > 1) ? $clog2(depth) : 1;

  logic [dataWidth-1:0] storage [depth];
  logic [dataWidth-1:0] readReg;

  always_ff @(posedge clock) begin
    if (port.writeEnable) begin
      storage[port.writeAddr[indexBits-1:0]] <= port.writeData;
    end
    // Registered read, one clock of latency
    readReg <= storage[port.readAddr[indexBits-1:0]];
  end

  assign port.readData = readReg;

endmodule

//--- hw/histogramPipeline.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counts one pixel per cycle into the scratchpad
// Counts are 16 bits wide and wrap, so N must stay below 2**16
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module histogramPipeline #(
  parameter int pixelWords = 4
) (
  input logic clock,
  input logic rst_n,
  input logic phaseReq,
  output logic phaseAck,
  memPort.master image,
  memPort.master scratch
);
  import histDataPkg::*;

  localparam int laneBits = $clog2(lanesPerWord);
  localparam logic [15:0] lastWord = 16'(pixelWords - 1);

  logic reqSeen, start, running, issuing, lastLane;
  logic [15:0] wordIdx;
  logic [laneBits-1:0] laneIdx;
  pixelT fpPixel;
  // Fetch-scratch stage
  logic fsValid;
  pixelT fsPixel;
  logic [15:0] fsBase;
  scratchEntryT fetched;
  // Accumulate stage, drives the write
  logic acValid;
  pixelT acPixel;
  logic [15:0] acBase, acCount;
  scratchEntryT written;
  // Store stage, last committed count
  logic stValid;
  pixelT stPixel;
  logic [15:0] stCount;

  assign start = phaseReq && !reqSeen;
  assign lastLane = laneIdx == laneBits'(lanesPerWord - 1);

  // Next word is addressed during lane 15 so lane 0 is ready next cycle
  assign image.readAddr = !issuing ? 16'd0 : (lastLane ? wordIdx + 16'd1 : wordIdx);
  assign image.writeAddr = '0;
  assign image.writeData = '0;
  assign image.writeEnable = 1'b0;
  assign fpPixel = image.readData[{laneIdx, 3'b000} +: 8];

  assign fetched = scratch.readData;
  assign acCount = acBase + 16'd1;

  // Newer in-flight counts win over the memory copy
  always_comb begin
    if (acValid && acPixel == fsPixel) begin
      fsBase = acCount;
    end else if (stValid && stPixel == fsPixel) begin
      fsBase = stCount;
    end else if (fetched.countView.tag == countTag) begin
      fsBase = fetched.countView.count;
    end else begin
      // Stale tag from an earlier run
      fsBase = 16'd0;
    end
    written.countView.tag = countTag;
    written.countView.count = acCount;
  end

  assign scratch.readAddr = fpPixel;
  assign scratch.writeAddr = acPixel;
  assign scratch.writeData = written;
  assign scratch.writeEnable = acValid;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      reqSeen <= 1'b0;
      running <= 1'b0;
      issuing <= 1'b0;
      wordIdx <= '0;
      laneIdx <= '0;
      fsValid <= 1'b0;
      acValid <= 1'b0;
      stValid <= 1'b0;
      phaseAck <= 1'b0;
    end else begin
      reqSeen <= phaseReq;
      fsValid <= issuing;
      acValid <= fsValid;
      stValid <= acValid;
      if (!phaseReq) begin
        phaseAck <= 1'b0;
      end
      if (start) begin
        running <= 1'b1;
        issuing <= 1'b1;
        wordIdx <= '0;
        laneIdx <= '0;
      end else if (issuing) begin
        laneIdx <= laneIdx + 1'b1;
        if (lastLane) begin
          wordIdx <= wordIdx + 16'd1;
          issuing <= wordIdx != lastWord;
        end
      end else if (running && !fsValid && !acValid) begin
        // Last write went in at the previous edge
        running <= 1'b0;
        phaseAck <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    fsPixel <= fpPixel;
    acPixel <= fsPixel;
    acBase <= fsBase;
    stPixel <= acPixel;
    stCount <= acCount;
  end

endmodule

//--- hw/cdfMapper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Level is floor(cdf * 255 / N); N must be a power of two, below 2**16
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module cdfMapper #(
  parameter int pixelWords = 4
) (
  input logic clock,
  input logic rst_n,
  input logic phaseReq,
  output logic phaseAck,
  memPort.master scratch
);
  import histDataPkg::*;
  import histCtrlPkg::*;

  localparam int pixelCount = pixelWords * lanesPerWord;
  // Divide by N as a shift
  localparam int levelShift = $clog2(pixelCount);

  logic reqSeen, start, running, writeCycle, lastBin;
  binAddrT bin;
  logic [15:0] cdf, cdfNext;
  logic [23:0] scaled;
  scratchEntryT fetched, mapped;

  assign start = phaseReq && !reqSeen;
  assign lastBin = bin == binAddrT'(binCount - 1);
  assign fetched = scratch.readData;

  always_comb begin
    // Only counts from this run add to the cdf
    if (fetched.countView.tag == countTag) begin
      cdfNext = cdf + fetched.countView.count;
    end else begin
      cdfNext = cdf;
    end
    scaled = {8'd0, cdfNext} * 24'd255;
    mapped.mapView.tag = mapTag;
    mapped.mapView.level = scaled[levelShift +: 8];
    mapped.mapView.unused = 8'd0;
  end

  // Read on the first cycle of a bin, write on the second
  assign scratch.readAddr = bin;
  assign scratch.writeAddr = bin;
  assign scratch.writeData = mapped;
  assign scratch.writeEnable = running && writeCycle;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      reqSeen <= 1'b0;
      running <= 1'b0;
      writeCycle <= 1'b0;
      bin <= '0;
      cdf <= '0;
      phaseAck <= 1'b0;
    end else begin
      reqSeen <= phaseReq;
      if (!phaseReq) begin
        phaseAck <= 1'b0;
      end
      if (start) begin
        running <= 1'b1;
        writeCycle <= 1'b0;
        bin <= '0;
        cdf <= '0;
      end else if (running) begin
        writeCycle <= !writeCycle;
        if (writeCycle) begin
          bin <= bin + 1'b1;
          cdf <= cdfNext;
          if (lastBin) begin
            running <= 1'b0;
            phaseAck <= 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- hw/pixelRemapper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects every scratch entry to hold a map entry; the tag is not checked
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pixelRemapper #(
  parameter int pixelWords = 4
) (
  input logic clock,
  input logic rst_n,
  input logic phaseReq,
  output logic phaseAck,
  memPort.master image,
  memPort.master scratch,
  memPort.master result
);
  import histDataPkg::*;

  localparam int laneBits = $clog2(lanesPerWord);
  localparam logic [15:0] lastWord = 16'(pixelWords - 1);

  logic reqSeen, start, running, issuing, lastLane;
  logic [15:0] wordIdx;
  logic [laneBits-1:0] laneIdx;
  // Lookup stage
  logic lkValid;
  logic [laneBits-1:0] lkLane;
  logic [15:0] lkWord;
  scratchEntryT looked;
  // Write stage
  imageWordT assembly;
  logic wrValid;
  logic [15:0] wrWord;

  assign start = phaseReq && !reqSeen;
  assign lastLane = laneIdx == laneBits'(lanesPerWord - 1);
  assign looked = scratch.readData;

  // Same word walk as the histogram phase
  assign image.readAddr = !issuing ? 16'd0 : (lastLane ? wordIdx + 16'd1 : wordIdx);
  assign image.writeAddr = '0;
  assign image.writeData = '0;
  assign image.writeEnable = 1'b0;

  // Pixel value is the scratch address
  assign scratch.readAddr = image.readData[{laneIdx, 3'b000} +: 8];
  assign scratch.writeAddr = '0;
  assign scratch.writeData = '0;
  assign scratch.writeEnable = 1'b0;

  assign result.readAddr = '0;
  assign result.writeAddr = wrWord;
  assign result.writeData = assembly;
  assign result.writeEnable = wrValid;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      reqSeen <= 1'b0;
      running <= 1'b0;
      issuing <= 1'b0;
      wordIdx <= '0;
      laneIdx <= '0;
      lkValid <= 1'b0;
      wrValid <= 1'b0;
      phaseAck <= 1'b0;
    end else begin
      reqSeen <= phaseReq;
      lkValid <= issuing;
      // Word complete once lane 15 lands
      wrValid <= lkValid && lkLane == laneBits'(lanesPerWord - 1);
      if (!phaseReq) begin
        phaseAck <= 1'b0;
      end
      if (start) begin
        running <= 1'b1;
        issuing <= 1'b1;
        wordIdx <= '0;
        laneIdx <= '0;
      end else if (issuing) begin
        laneIdx <= laneIdx + 1'b1;
        if (lastLane) begin
          wordIdx <= wordIdx + 16'd1;
          issuing <= wordIdx != lastWord;
        end
      end else if (running && !lkValid && !wrValid) begin
        running <= 1'b0;
        phaseAck <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    lkLane <= laneIdx;
    lkWord <= wordIdx;
    wrWord <= lkWord;
    if (lkValid) begin
      assembly[{lkLane, 3'b000} +: 8] <= looked.mapView.level;
    end
  end

endmodule

//--- hw/histEqualizer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host loads and reads only while idle. pixelWords * 16 must be a power of 2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module histEqualizer #(
  parameter int pixelWords = 4
) (
  input logic clock,
  input logic rst_n,
  input logic loadEnable,
  input logic [15:0] loadAddr,
  input histDataPkg::imageWordT loadData,
  input logic startReq,
  input logic [15:0] readAddr,
  output logic startAck,
  output histDataPkg::imageWordT readData
);
  import histDataPkg::*;
  import histCtrlPkg::*;

  runPhaseT phase;
  logic reqActive, phaseAckSel;
  logic histReq, histAck, mapReq, mapAck, remapReq, remapAck;

  // One bus per memory plus one per block port
  memPort #(.addrWidth(16), .dataWidth($bits(imageWordT)))
    imageBus(), histImage(), remapImage(), resultBus(), remapResult();
  memPort #(.addrWidth($bits(binAddrT)), .dataWidth($bits(scratchEntryT)))
    scratchBus(), histScratch(), mapScratch(), remapScratch();

  // Only the block of the current phase sees its request
  assign histReq = reqActive && phase == phaseHistogram;
  assign mapReq = reqActive && phase == phaseMapping;
  assign remapReq = reqActive && phase == phaseRemap;

  always_comb begin
    case (phase)
      phaseHistogram: phaseAckSel = histAck;
      phaseMapping: phaseAckSel = mapAck;
      phaseRemap: phaseAckSel = remapAck;
      default: phaseAckSel = 1'b0;
    endcase
  end

  // Four-phase exchange with each block, then with the host
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      phase <= phaseIdle;
      reqActive <= 1'b0;
      startAck <= 1'b0;
    end else if (phase == phaseIdle) begin
      if (startReq && !startAck) begin
        phase <= phaseHistogram;
        reqActive <= 1'b1;
      end else if (!startReq) begin
        startAck <= 1'b0;
      end
    end else if (reqActive) begin
      if (phaseAckSel) begin
        reqActive <= 1'b0;
      end
    end else if (!phaseAckSel) begin
      // Block has dropped its ack
      if (phase == phaseRemap) begin
        phase <= phaseIdle;
        startAck <= 1'b1;
      end else begin
        phase <= (phase == phaseHistogram) ? phaseMapping : phaseRemap;
        reqActive <= 1'b1;
      end
    end
  end

  // Image memory, host writes only while idle
  assign imageBus.readAddr = (phase == phaseHistogram) ? histImage.readAddr :
                             (phase == phaseRemap) ? remapImage.readAddr : 16'd0;
  assign imageBus.writeAddr = loadAddr;
  assign imageBus.writeData = loadData;
  assign imageBus.writeEnable = loadEnable && phase == phaseIdle;
  assign histImage.readData = imageBus.readData;
  assign remapImage.readData = imageBus.readData;

  // Scratchpad goes to whichever block owns the phase
  always_comb begin
    case (phase)
      phaseHistogram: begin
        scratchBus.readAddr = histScratch.readAddr;
        scratchBus.writeAddr = histScratch.writeAddr;
        scratchBus.writeData = histScratch.writeData;
        scratchBus.writeEnable = histScratch.writeEnable;
      end
      phaseMapping: begin
        scratchBus.readAddr = mapScratch.readAddr;
        scratchBus.writeAddr = mapScratch.writeAddr;
        scratchBus.writeData = mapScratch.writeData;
        scratchBus.writeEnable = mapScratch.writeEnable;
      end
      phaseRemap: begin
        scratchBus.readAddr = remapScratch.readAddr;
        scratchBus.writeAddr = remapScratch.writeAddr;
        scratchBus.writeData = remapScratch.writeData;
        scratchBus.writeEnable = remapScratch.writeEnable;
      end
      default: begin
        scratchBus.readAddr = '0;
        scratchBus.writeAddr = '0;
        scratchBus.writeData = '0;
        scratchBus.writeEnable = 1'b0;
      end
    endcase
  end
  assign histScratch.readData = scratchBus.readData;
  assign mapScratch.readData = scratchBus.readData;
  assign remapScratch.readData = scratchBus.readData;

  // Output memory, remapper writes and host reads
  assign resultBus.readAddr = (phase == phaseIdle) ? readAddr : remapResult.readAddr;
  assign resultBus.writeAddr = remapResult.writeAddr;
  assign resultBus.writeData = remapResult.writeData;
  assign resultBus.writeEnable = remapResult.writeEnable && phase == phaseRemap;
  assign remapResult.readData = resultBus.readData;
  assign readData = resultBus.readData;

  wordMemory #(.dataWidth($bits(imageWordT)), .depth(pixelWords)) imageMem (
    .clock(clock),
    .port(imageBus.slave)
  );

  wordMemory #(.dataWidth($bits(scratchEntryT)), .depth(binCount)) scratchMem (
    .clock(clock),
    .port(scratchBus.slave)
  );

  wordMemory #(.dataWidth($bits(imageWordT)), .depth(pixelWords)) resultMem (
    .clock(clock),
    .port(resultBus.slave)
  );

  histogramPipeline #(.pixelWords(pixelWords)) histogram (
    .clock(clock),
    .rst_n(rst_n),
    .phaseReq(histReq),
    .phaseAck(histAck),
    .image(histImage.master),
    .scratch(histScratch.master)
  );

  cdfMapper #(.pixelWords(pixelWords)) mapper (
    .clock(clock),
    .rst_n(rst_n),
    .phaseReq(mapReq),
    .phaseAck(mapAck),
    .scratch(mapScratch.master)
  );

  pixelRemapper #(.pixelWords(pixelWords)) remapper (
    .clock(clock),
    .rst_n(rst_n),
    .phaseReq(remapReq),
    .phaseAck(remapAck),
    .image(remapImage.master),
    .scratch(remapScratch.master),
    .result(remapResult.master)
  );

endmodule

//--- sim/histEqualizer_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound into histEqualizer; samples the host handshake and the block writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module histEqualizerProperties (
  input logic clock,
  input logic rst_n,
  input logic startReq,
  input logic startAck,
  input histCtrlPkg::runPhaseT phase,
  input logic scratchWrite,
  input logic resultWrite
);
  import histCtrlPkg::*;

  // Host handshake, ack follows the request both ways
  ackRise: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(startAck) |-> startReq)
    else $error("startAck rose while startReq was low");

  ackFall: assert property (@(posedge clock) disable iff (!rst_n)
    $fell(startAck) |-> !startReq)
    else $error("startAck fell while startReq was high");

  // Remap only reads the levels
  remapScratchRead: assert property (@(posedge clock) disable iff (!rst_n)
    phase == phaseRemap |-> !scratchWrite)
    else $error("Scratchpad written during remap");

  resultInRemap: assert property (@(posedge clock) disable iff (!rst_n)
    phase != phaseRemap |-> !resultWrite)
    else $error("Output memory written outside remap");

endmodule

bind histEqualizer histEqualizerProperties checks (
  .clock(clock),
  .rst_n(rst_n),
  .startReq(startReq),
  .startAck(startAck),
  .phase(phase),
  // Write requests straight from the blocks, ahead of the phase steering
  .scratchWrite(histScratch.writeEnable || mapScratch.writeEnable ||
                remapScratch.writeEnable),
  .resultWrite(remapResult.writeEnable)
);

//--- sim/histEqualizerTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Words come from sim/histEqualizerInput.txt, so run from the project root
// Assumes pixelWords of 4, eight file words per test, no reset between tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module histEqualizerTb;
  import histDataPkg::*;

  localparam int pixelWords = 4;
  localparam int pixelCount = pixelWords * lanesPerWord;
  localparam int testCount = 3;
  // Image words, then expected output words
  localparam int wordsPerTest = 2 * pixelWords;
  localparam int resetCycles = 16;
  // Two image passes plus the bin scan, per run
  localparam int cycleLimit = testCount * (2 * pixelCount + 600) + resetCycles;

  logic clock;
  logic rst_n;
  logic loadEnable;
  logic [15:0] loadAddr;
  imageWordT loadData;
  logic startReq;
  logic [15:0] readAddr;
  logic startAck;
  imageWordT readData;

  imageWordT vectors [testCount * wordsPerTest];
  logic [31:0] lfsrState;
  int cycleCount;
  int checkCount;
  int errorCount;

  histEqualizer #(.pixelWords(pixelWords)) DUT (
    .clock(clock),
    .rst_n(rst_n),
    .loadEnable(loadEnable),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .startReq(startReq),
    .readAddr(readAddr),
    .startAck(startAck),
    .readData(readData)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Stops a run that hangs
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("** FAIL **");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    lfsrStep = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit
  task automatic takeRandomBits(input int bitCount, output int value);
    value = 0;
    for (int b = 0; b < bitCount; b++) begin
      lfsrState = lfsrStep(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic string describeTest(input int index);
    case (index)
      0: describeTest = "uniform image";
      1: describeTest = "runs of equal pixels";
      default: describeTest = "ramp image";
    endcase
  endfunction

  // Host writes the image while the design is idle
  task automatic loadImage(input int base);
    for (int w = 0; w < pixelWords; w++) begin
      @(posedge clock);
      loadEnable <= 1'b1;
      loadAddr <= 16'(w);
      loadData <= vectors[base + w];
    end
    @(posedge clock);
    loadEnable <= 1'b0;
  endtask

  // Full four-phase exchange with a junk load in the middle of the run
  task automatic runImage();
    int idleCycles;
    @(negedge clock);
    checkValue("startAck", 128'(startAck), 128'd0);
    @(posedge clock);
    startReq <= 1'b1;
    @(posedge clock);
    @(posedge clock);
    // Design is busy here, these writes must be dropped
    for (int w = 0; w < pixelWords; w++) begin
      loadEnable <= 1'b1;
      loadAddr <= 16'(w);
      loadData <= '1;
      @(posedge clock);
    end
    loadEnable <= 1'b0;
    @(negedge clock);
    while (!startAck) @(negedge clock);
    // Ack has to hold while the request stays up
    takeRandomBits(3, idleCycles);
    repeat (idleCycles) begin
      @(negedge clock);
      checkValue("startAck", 128'(startAck), 128'd1);
    end
    @(posedge clock);
    startReq <= 1'b0;
    @(negedge clock);
    while (startAck) @(negedge clock);
  endtask

  // Read port has one clock of latency
  task automatic readResult(input int base);
    for (int w = 0; w < pixelWords; w++) begin
      @(posedge clock);
      readAddr <= 16'(w);
      @(posedge clock);
      @(negedge clock);
      checkValue($sformatf("readData word %0d", w), readData, vectors[base + w]);
    end
  endtask

  initial begin
    int errorsBefore;
    rst_n = 1'b0;
    loadEnable = 1'b0;
    loadAddr = '0;
    loadData = '0;
    startReq = 1'b0;
    readAddr = '0;
    lfsrState = 32'hccd45849;
    checkCount = 0;
    errorCount = 0;
    $readmemh("sim/histEqualizerInput.txt", vectors);
    repeat (resetCycles) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    checkValue("startAck", 128'(startAck), 128'd0);
    // Back-to-back runs, scratch keeps the tags of the previous run
    for (int t = 0; t < testCount; t++) begin
      errorsBefore = errorCount;
      loadImage(t * wordsPerTest);
      runImage();
      readResult(t * wordsPerTest + pixelWords);
      $display("Test %0d (%s) finished with %0d errors", t, describeTest(t),
               errorCount - errorsBefore);
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim/histEqualizerInput.txt
// One 128-bit hex word per line, pixel lane 0 in the low byte
// Per test: four image words, then the four expected output words
// Test 0: every pixel 0x3c
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
ffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffff
// Test 1: runs of 0x10 and 0x80, then 0xf0 and 0x80 alternating
10101010101010101010101010101010
80808080808080801010101010101010
80808080808080808080808080808080
80f080f080f080f080f080f080f080f0
5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f
dfdfdfdfdfdfdfdf5f5f5f5f5f5f5f5f
dfdfdfdfdfdfdfdfdfdfdfdfdfdfdfdf
dfffdfffdfffdfffdfffdfffdfffdfff
// Test 2: ramp 0x00 to 0xfc in steps of four
3c3834302c2824201c1814100c080400
7c7874706c6864605c5854504c484440
bcb8b4b0aca8a4a09c9894908c888480
fcf8f4f0ece8e4e0dcd8d4d0ccc8c4c0
3f3b37332f2b27231f1b17130f0b0703
7f7b77736f6b67635f5b57534f4b4743
bfbbb7b3afaba7a39f9b97938f8b8783
fffbf7f3efebe7e3dfdbd7d3cfcbc7c3

//--- histEqualizer.f
hw/histDataPkg.sv
hw/histCtrlPkg.sv
hw/memPort.sv
hw/wordMemory.sv
hw/histogramPipeline.sv
hw/cdfMapper.sv
hw/pixelRemapper.sv
hw/histEqualizer.sv
sim/histEqualizer_properties.sv
sim/histEqualizerTb.sv

//--- Makefile
# Verilator build and run of the histogram equalizer testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module histEqualizerTb -f histEqualizer.f

# The log decides pass or fail
run: compile
	obj_dir/VhistEqualizerTb | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
